//--- cop_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main CPU bus definitions for the video control registers
// Widths, address fields and the request and access records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cop_bus_pkg;

    localparam int cpu_addr_w = 12;
    localparam int cpu_data_w = 16;

    // Word address layout
    localparam int region_hi = 11;
    localparam int region_lo = 10;
    localparam int region_w  = region_hi - region_lo + 1;
    localparam int bank_bit  = 9;
    localparam int idx_w     = 2;

    // Region 3 goes to the MCU latch, 0 to 2 are the tile layers
    localparam logic [region_w-1:0] region_mcu = 2'd3;

    // One CPU bus cycle, valid while cs is high
    typedef struct packed {
        logic                  cs;
        logic                  rnw;
        logic [1:0]            dsn;    // active low, bit 1 is the high byte
        logic [cpu_addr_w-1:0] addr;
        logic [cpu_data_w-1:0] dout;
    } cpu_req_t;

    // Decoded access to one layer
    typedef struct packed {
        logic                  wr;
        logic                  rd;
        logic                  scroll;
        logic [idx_w-1:0]      idx;
        logic [1:0]            dsn;
        logic [cpu_data_w-1:0] data;
    } layer_acc_t;

    // Follows a read down the pipeline
    typedef struct packed {
        logic                valid;
        logic [region_w-1:0] src;
    } rd_tag_t;

endpackage

//--- cop_layer_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile layer register definitions
// Register counts, the per-layer register record and status codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cop_layer_pkg;

    import cop_bus_pkg::*;

    // Three identical layers on the board
    localparam int layer_n = 3;

    localparam int mode_n   = 4;
    localparam int scroll_n = 2;

    // Status selector value that dumps the MCU latch
    localparam logic [1:0] st_sel_mcu = 2'd3;

    // Full control state of one layer, as seen by the renderer
    typedef struct packed {
        logic [mode_n-1:0][cpu_data_w-1:0]   mode;
        logic [scroll_n-1:0][cpu_data_w-1:0] scroll;
    } layer_regs_t;

endpackage

//--- cop_bus_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus decoder
// Turns main CPU requests into layer strobes, MCU writes and read tags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cop_bus_decode
    import cop_bus_pkg::*, cop_layer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst24,
    input  cpu_req_t              cpu_req,
    output layer_acc_t            acc [layer_n],
    output logic                  mcu_wr,
    output logic [cpu_data_w-1:0] mcu_wdata,
    output rd_tag_t               rd_tag
);

    cpu_req_t            req_q;
    logic [region_w-1:0] region;
    logic                bank;
    logic [idx_w-1:0]    idx;
    logic                legal;
    logic                wr_req;
    logic                rd_req;

    // Address fields of the held request
    assign region = req_q.addr[region_hi:region_lo];
    assign bank   = req_q.addr[bank_bit];
    assign idx    = req_q.addr[idx_w-1:0];

    // Scroll bank only has two words
    assign legal  = !bank || (idx < scroll_n);
    assign wr_req = req_q.cs && !req_q.rnw;
    assign rd_req = req_q.cs && req_q.rnw;

    always_ff @(posedge clk, posedge rst24) begin
        if (rst24) begin
            req_q <= '0;
        end else begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clk, posedge rst24) begin
        if (rst24) begin
            for (int l = 0; l < layer_n; l++) begin
                acc[l] <= '0;
            end
            mcu_wr    <= 1'b0;
            mcu_wdata <= '0;
            rd_tag    <= '0;
        end else begin
            for (int l = 0; l < layer_n; l++) begin
                acc[l].wr     <= wr_req && legal && (region == region_w'(l));
                acc[l].rd     <= rd_req && legal && (region == region_w'(l));
                acc[l].scroll <= bank;
                acc[l].idx    <= idx;
                acc[l].dsn    <= req_q.dsn;
                acc[l].data   <= req_q.dout;
            end
            mcu_wr    <= wr_req && (region == region_mcu);
            mcu_wdata <= req_q.dout;
            // Illegal reads still get a tag so the reply slot is kept
            rd_tag.valid <= rd_req;
            rd_tag.src   <= region;
        end
    end

endmodule

//--- cop_tile_layer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control registers of one tile layer
// Four mode words and two scroll words with byte writes and readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cop_tile_layer
    import cop_bus_pkg::*, cop_layer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst24,
    input  layer_acc_t            acc,
    output logic [cpu_data_w-1:0] rd_data,
    output layer_regs_t           cfg
);

    logic [cpu_data_w-1:0] cur_word;

    // Merge the new data into the old word under the byte strobes
    function automatic logic [cpu_data_w-1:0] merge_bytes(
        input logic [cpu_data_w-1:0] old_w,
        input logic [cpu_data_w-1:0] new_w,
        input logic [1:0]            dsn
    );
        logic [cpu_data_w-1:0] res;
        res = old_w;
        if (!dsn[1]) begin
            res[15:8] = new_w[15:8];
        end
        if (!dsn[0]) begin
            res[7:0] = new_w[7:0];
        end
        return res;
    endfunction

    // Addressed word, scroll bank uses the low index bit only
    always_comb begin
        if (acc.scroll) begin
            cur_word = cfg.scroll[acc.idx[0]];
        end else begin
            cur_word = cfg.mode[acc.idx];
        end
    end

    always_ff @(posedge clk, posedge rst24) begin
        if (rst24) begin
            cfg <= '0;
        end else if (acc.wr) begin
            if (acc.scroll) begin
                cfg.scroll[acc.idx[0]] <= merge_bytes(cur_word, acc.data, acc.dsn);
            end else begin
                cfg.mode[acc.idx] <= merge_bytes(cur_word, acc.data, acc.dsn);
            end
        end
    end

    // Read word is zero unless this layer was strobed
    always_ff @(posedge clk, posedge rst24) begin
        if (rst24) begin
            rd_data <= '0;
        end else if (acc.rd) begin
            rd_data <= cur_word;
        end else begin
            rd_data <= '0;
        end
    end

endmodule

//--- cop_readback_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU readback and status dump
// Aligns read tags with layer data and picks status bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cop_readback_mux
    import cop_bus_pkg::*, cop_layer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst24,
    input  rd_tag_t               rd_tag,
    input  logic [cpu_data_w-1:0] rd_data [layer_n],
    input  layer_regs_t           layer_cfg [layer_n],
    input  logic [cpu_data_w-1:0] mcu_dout,
    input  logic [cpu_data_w-1:0] mcu_latch,
    input  logic [7:0]            st_addr,
    output logic [cpu_data_w-1:0] cpu_din,
    output logic                  cpu_dok,
    output logic [7:0]            st_dout
);

    rd_tag_t    tag_q;
    logic [1:0] st_sel;
    logic [7:0] st_byte;

    // Bytes 0-7 mode, 8-11 scroll, low byte first, rest reads zero
    function automatic logic [7:0] layer_byte(
        input layer_regs_t r,
        input logic [3:0]  sel
    );
        logic [cpu_data_w-1:0] w;
        w = '0;
        if (sel < 4'd8) begin
            w = r.mode[sel[2:1]];
        end else if (sel < 4'd12) begin
            w = r.scroll[sel[1]];
        end
        return sel[0] ? w[15:8] : w[7:0];
    endfunction

    assign st_sel = st_addr[7:6];

    always_comb begin
        if (st_sel == st_sel_mcu) begin
            st_byte = st_addr[0] ? mcu_latch[15:8] : mcu_latch[7:0];
        end else begin
            st_byte = layer_byte(layer_cfg[st_sel], st_addr[3:0]);
        end
    end

    // Tag waits one cycle for the layer read word.
    // An illegal read arrives here as a zero word from its layer
    always_ff @(posedge clk, posedge rst24) begin
        if (rst24) begin
            tag_q   <= '0;
            cpu_dok <= 1'b0;
            cpu_din <= '0;
            st_dout <= '0;
        end else begin
            tag_q   <= rd_tag;
            cpu_dok <= tag_q.valid;
            st_dout <= st_byte;
            if (tag_q.valid) begin
                if (tag_q.src == region_mcu) begin
                    cpu_din <= mcu_dout;
                end else begin
                    cpu_din <= rd_data[tag_q.src];
                end
            end
        end
    end

endmodule

//--- cop_mcu_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Port glue between the main CPU and the protection MCU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cop_mcu_glue
    import cop_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst24,
    input  logic                  mcu_wr,
    input  logic [cpu_data_w-1:0] mcu_wdata,
    input  logic [7:0]            mcu_p0o,
    input  logic [7:0]            mcu_p2o,
    output logic [7:0]            mcu_p0i,
    output logic                  mcu_intn,
    output logic [cpu_data_w-1:0] mcu_dout,
    output logic [cpu_data_w-1:0] mcu_latch
);

    logic mcu_sel;
    logic mcu_sel_l;

    always_ff @(posedge clk, posedge rst24) begin
        if (rst24) begin
            mcu_sel   <= 1'b0;
            mcu_sel_l <= 1'b0;
            mcu_intn  <= 1'b1;
            mcu_latch <= '0;
            mcu_p0i   <= '0;
            mcu_dout  <= '0;
        end else begin
            // CPU side latch and select
            mcu_sel   <= mcu_wr;
            mcu_sel_l <= mcu_sel;
            if (mcu_wr) begin
                mcu_latch <= mcu_wdata;
            end

            // P2.3 acknowledges, takes priority over a new edge
            if (!mcu_p2o[3]) begin
                mcu_intn <= 1'b1;
            end else if (mcu_sel && !mcu_sel_l) begin
                mcu_intn <= 1'b0;
            end

            // MCU reads the latch through port 0
            if (!mcu_p2o[4]) begin
                mcu_p0i <= mcu_latch[15:8];
            end
            if (!mcu_p2o[5]) begin
                mcu_p0i <= mcu_latch[7:0];
            end

            // MCU writes back a word one byte at a time
            if (!mcu_p2o[7]) begin
                mcu_dout[15:8] <= mcu_p0o;
            end
            if (!mcu_p2o[6]) begin
                mcu_dout[7:0] <= mcu_p0o;
            end
        end
    end

endmodule

//--- cop_video_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video board control registers, CPU facing side
// Bus decoder, three tile layer banks, readback and MCU port glue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cop_video_regs
    import cop_bus_pkg::*, cop_layer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst24,
    input  cpu_req_t              cpu_req,
    output logic [cpu_data_w-1:0] cpu_din,
    output logic                  cpu_dok,
    output layer_regs_t           layer_cfg [layer_n],
    input  logic [7:0]            st_addr,
    output logic [7:0]            st_dout,
    input  logic [7:0]            mcu_p0o,
    input  logic [7:0]            mcu_p2o,
    output logic [7:0]            mcu_p0i,
    output logic                  mcu_intn,
    output logic [cpu_data_w-1:0] mcu_dout
);

    layer_acc_t            acc [layer_n];
    logic [cpu_data_w-1:0] rd_data [layer_n];
    rd_tag_t               rd_tag;
    logic                  mcu_wr;
    logic [cpu_data_w-1:0] mcu_wdata;
    logic [cpu_data_w-1:0] mcu_latch;

    cop_bus_decode u_decode (
        .clk       ( clk       ),
        .rst24     ( rst24     ),
        .cpu_req   ( cpu_req   ),
        .acc       ( acc       ),
        .mcu_wr    ( mcu_wr    ),
        .mcu_wdata ( mcu_wdata ),
        .rd_tag    ( rd_tag    )
    );

    for (genvar g = 0; g < layer_n; g++) begin : g_layer
        cop_tile_layer u_layer (
            .clk     ( clk          ),
            .rst24   ( rst24        ),
            .acc     ( acc[g]       ),
            .rd_data ( rd_data[g]   ),
            .cfg     ( layer_cfg[g] )
        );
    end

    cop_mcu_glue u_mcu (
        .clk       ( clk       ),
        .rst24     ( rst24     ),
        .mcu_wr    ( mcu_wr    ),
        .mcu_wdata ( mcu_wdata ),
        .mcu_p0o   ( mcu_p0o   ),
        .mcu_p2o   ( mcu_p2o   ),
        .mcu_p0i   ( mcu_p0i   ),
        .mcu_intn  ( mcu_intn  ),
        .mcu_dout  ( mcu_dout  ),
        .mcu_latch ( mcu_latch )
    );

    cop_readback_mux u_mux (
        .clk       ( clk       ),
        .rst24     ( rst24     ),
        .rd_tag    ( rd_tag    ),
        .rd_data   ( rd_data   ),
        .layer_cfg ( layer_cfg ),
        .mcu_dout  ( mcu_dout  ),
        .mcu_latch ( mcu_latch ),
        .st_addr   ( st_addr   ),
        .cpu_din   ( cpu_din   ),
        .cpu_dok   ( cpu_dok   ),
        .st_dout   ( st_dout   )
    );

endmodule

//--- tb_cop_video_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the video control registers
// Shadow register model, reference results and a read reply checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_cop_video_regs
    import cop_bus_pkg::*, cop_layer_pkg::*;
;

    logic                  clk;
    logic                  rst24;
    cpu_req_t              cpu_req;
    logic [cpu_data_w-1:0] cpu_din;
    logic                  cpu_dok;
    layer_regs_t           layer_cfg [layer_n];
    logic [7:0]            st_addr;
    logic [7:0]            st_dout;
    logic [7:0]            mcu_p0o;
    logic [7:0]            mcu_p2o;
    logic [7:0]            mcu_p0i;
    logic                  mcu_intn;
    logic [cpu_data_w-1:0] mcu_dout;

    // Shadow model of the registers
    logic [15:0] mode_m   [layer_n][mode_n];
    logic [15:0] scroll_m [layer_n][scroll_n];
    logic [15:0] latch_m;
    logic [15:0] dout_m;

    // Expected word and due cycle of each outstanding read
    logic [15:0] exp_word [$];
    int          exp_due  [$];
    logic [15:0] want;
    int          due;

    int    seed = 32'he8ac;
    int    cyc;
    int    checks;
    int    errors;
    string test_name;

    cop_video_regs DUT (
        .clk      ( clk       ),
        .rst24    ( rst24     ),
        .cpu_req  ( cpu_req   ),
        .cpu_din  ( cpu_din   ),
        .cpu_dok  ( cpu_dok   ),
        .layer_cfg( layer_cfg ),
        .st_addr  ( st_addr   ),
        .st_dout  ( st_dout   ),
        .mcu_p0o  ( mcu_p0o   ),
        .mcu_p2o  ( mcu_p2o   ),
        .mcu_p0i  ( mcu_p0i   ),
        .mcu_intn ( mcu_intn  ),
        .mcu_dout ( mcu_dout  )
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Expected CPU read word for a word address
    function automatic logic [15:0] ref_read(input logic [11:0] addr);
        logic [1:0] region;
        logic [1:0] idx;
        region = addr[11:10];
        idx    = addr[1:0];
        if (region == 2'd3) begin
            return dout_m;
        end
        if (addr[9]) begin
            return (idx < 2) ? scroll_m[region][idx[0]] : 16'h0000;
        end
        return mode_m[region][idx];
    endfunction

    // Expected status byte for a status address
    function automatic logic [7:0] ref_status(input logic [7:0] sa);
        logic [15:0] w;
        logic [3:0]  b;
        b = sa[3:0];
        w = 16'h0000;
        if (sa[7:6] == 2'd3) begin
            w = latch_m;
            b = {3'd0, sa[0]};
        end else if (b < 8) begin
            w = mode_m[sa[7:6]][b / 2];
        end else if (b < 12) begin
            w = scroll_m[sa[7:6]][(b - 8) / 2];
        end
        return b[0] ? w[15:8] : w[7:0];
    endfunction

    function automatic logic [11:0] layer_addr(input int l, input bit bank, input int i);
        return {2'(l), bank, 7'd0, 2'(i)};
    endfunction

    task automatic report_mismatch(input logic [15:0] exp_v, input logic [15:0] act_v);
        $display("CHECK FAILED %s: expected %h actual %h", test_name, exp_v, act_v);
        errors++;
    endtask

    task automatic drive_write(input logic [11:0] addr, input logic [1:0] dsn,
                               input logic [15:0] data);
        @(negedge clk);
        cpu_req.cs   = 1'b1;
        cpu_req.rnw  = 1'b0;
        cpu_req.dsn  = dsn;
        cpu_req.addr = addr;
        cpu_req.dout = data;
        if (addr[11:10] == 2'd3) begin
            latch_m = data;
        end else if (!addr[9]) begin
            if (!dsn[1]) mode_m[addr[11:10]][addr[1:0]][15:8] = data[15:8];
            if (!dsn[0]) mode_m[addr[11:10]][addr[1:0]][7:0] = data[7:0];
        end else if (addr[1:0] < 2) begin
            if (!dsn[1]) scroll_m[addr[11:10]][addr[0]][15:8] = data[15:8];
            if (!dsn[0]) scroll_m[addr[11:10]][addr[0]][7:0] = data[7:0];
        end
    endtask

    task automatic drive_read(input logic [11:0] addr);
        @(negedge clk);
        cpu_req.cs   = 1'b1;
        cpu_req.rnw  = 1'b1;
        cpu_req.dsn  = 2'b00;
        cpu_req.addr = addr;
        cpu_req.dout = 16'h0000;
        exp_word.push_back(ref_read(addr));
        exp_due.push_back(cyc + 4);
    endtask

    task automatic drive_idle();
        @(negedge clk);
        cpu_req = '0;
    endtask

    task automatic wait_reads_done();
        for (int n = 0; n < 20 && exp_word.size() != 0; n++) begin
            @(negedge clk);
        end
        if (exp_word.size() != 0) begin
            $display("%s: timeout, %0d read replies never arrived", test_name, exp_word.size());
            errors++;
        end
    endtask

    task automatic wait_intn(input logic level);
        for (int n = 0; n < 8 && mcu_intn !== level; n++) begin
            @(negedge clk);
        end
        if (mcu_intn !== level) begin
            $display("%s: timeout waiting for mcu_intn to go %b", test_name, level);
            errors++;
        end
    endtask

    task automatic check_layer_cfg();
        for (int l = 0; l < layer_n; l++) begin
            for (int i = 0; i < mode_n; i++) begin
                checks++;
                if (layer_cfg[l].mode[i] !== mode_m[l][i]) begin
                    report_mismatch(mode_m[l][i], layer_cfg[l].mode[i]);
                end
            end
            for (int i = 0; i < scroll_n; i++) begin
                checks++;
                if (layer_cfg[l].scroll[i] !== scroll_m[l][i]) begin
                    report_mismatch(scroll_m[l][i], layer_cfg[l].scroll[i]);
                end
            end
        end
    endtask

    task automatic load_p0i(input logic [7:0] p2, input logic [7:0] exp_b);
        @(negedge clk);
        mcu_p2o = p2;
        @(negedge clk);
        checks++;
        if (mcu_p0i !== exp_b) begin
            report_mismatch(exp_b, mcu_p0i);
        end
    endtask

    // Compares each read reply with the oldest outstanding read
    always @(negedge clk) begin
        if (!rst24 && cpu_dok) begin
            if (exp_word.size() == 0) begin
                $display("%s: cpu_dok pulse with no read outstanding", test_name);
                errors++;
            end else begin
                want = exp_word.pop_front();
                due  = exp_due.pop_front();
                checks++;
                if (cpu_din !== want) begin
                    report_mismatch(want, cpu_din);
                end
                if (cyc != due) begin
                    $display("CHECK FAILED %s latency: expected cycle %0d actual cycle %0d",
                             test_name, due, cyc);
                    errors++;
                end
            end
        end
    end

    initial begin
        clk       = 1'b0;
        rst24     = 1'b1;
        cpu_req   = '0;
        st_addr   = 8'h00;
        mcu_p0o   = 8'h00;
        mcu_p2o   = 8'hff;
        cyc       = 0;
        checks    = 0;
        errors    = 0;
        latch_m   = 16'h0000;
        dout_m    = 16'h0000;
        test_name = "reset";
        for (int l = 0; l < layer_n; l++) begin
            for (int i = 0; i < mode_n; i++) mode_m[l][i] = 16'h0000;
            for (int i = 0; i < scroll_n; i++) scroll_m[l][i] = 16'h0000;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst24 = 1'b0;

        // Every legal register written with random strobes then read back
        test_name = "layer_rw";
        for (int l = 0; l < layer_n; l++) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < (b ? scroll_n : mode_n); i++) begin
                    drive_write(layer_addr(l, b, i), 2'($random(seed)), 16'($random(seed)));
                    drive_read(layer_addr(l, b, i));
                end
            end
        end
        drive_idle();
        wait_reads_done();
        test_name = "layer_cfg";
        check_layer_cfg();

        test_name = "scroll_illegal";
        for (int l = 0; l < layer_n; l++) begin
            for (int i = 2; i < 4; i++) begin
                drive_write(layer_addr(l, 1, i), 2'b00, 16'($random(seed)));
                drive_read(layer_addr(l, 1, i));
            end
        end
        drive_idle();
        wait_reads_done();
        check_layer_cfg();

        // Back to back reads from random mode registers
        test_name = "read_burst";
        repeat (12) begin
            drive_read(layer_addr($unsigned($random(seed)) % 3, 1'b0,
                                  $unsigned($random(seed)) % 4));
        end
        drive_idle();
        wait_reads_done();

        test_name = "mcu_int";
        checks++;
        if (mcu_intn !== 1'b1) begin
            report_mismatch(16'h0001, {15'd0, mcu_intn});
        end
        drive_write({region_mcu, 10'd0}, 2'b00, 16'($random(seed)));
        drive_idle();
        wait_intn(1'b0);
        @(negedge clk);
        mcu_p2o = 8'hf7;
        wait_intn(1'b1);

        // Each load changes the byte so every step is visible
        test_name = "mcu_p0i";
        load_p0i(8'hef, latch_m[15:8]);
        load_p0i(8'hdf, latch_m[7:0]);
        load_p0i(8'hef, latch_m[15:8]);
        load_p0i(8'hcf, latch_m[7:0]);

        test_name = "mcu_dout";
        @(negedge clk);
        mcu_p0o = 8'($random(seed));
        mcu_p2o = 8'h7f;
        dout_m[15:8] = mcu_p0o;
        @(negedge clk);
        mcu_p0o = 8'($random(seed));
        mcu_p2o = 8'hbf;
        dout_m[7:0] = mcu_p0o;
        @(negedge clk);
        mcu_p2o = 8'hff;
        checks++;
        if (mcu_dout !== dout_m) begin
            report_mismatch(dout_m, mcu_dout);
        end
        drive_read({region_mcu, 10'd0});
        drive_idle();
        wait_reads_done();

        test_name = "status_dump";
        for (int a = 0; a < 256; a++) begin
            @(negedge clk);
            st_addr = 8'(a);
            @(negedge clk);
            checks++;
            if (st_dout !== ref_status(8'(a))) begin
                report_mismatch({8'd0, ref_status(8'(a))}, {8'd0, st_dout});
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- cop_video_regs.f
cop_bus_pkg.sv
cop_layer_pkg.sv
cop_bus_decode.sv
cop_tile_layer.sv
cop_readback_mux.sv
cop_mcu_glue.sv
cop_video_regs.sv
tb_cop_video_regs.sv

//--- Bender.yml
package:
  name: cop_video_regs

sources:
  - cop_bus_pkg.sv
  - cop_layer_pkg.sv
  - cop_bus_decode.sv
  - cop_tile_layer.sv
  - cop_readback_mux.sv
  - cop_mcu_glue.sv
  - cop_video_regs.sv
  - target: test
    files:
      - tb_cop_video_regs.sv
